/* src/clk_ctrl_pkg.sv */
// clock control shared definitions
`default_nettype none

package clk_ctrl_pkg;

  // ------------------------------------------------------------------------
  // ctrlport widths
  // ------------------------------------------------------------------------
  localparam int CTRL_ADDR_W = 20;
  localparam int CTRL_DATA_W = 32;
  localparam int CTRL_STS_W  = 2;

  typedef logic [CTRL_ADDR_W-1:0] ctrl_addr_t;
  typedef logic [CTRL_DATA_W-1:0] ctrl_data_t;
  typedef logic [CTRL_STS_W-1:0]  ctrl_status_t;

  // response status codes
  localparam ctrl_status_t CTRL_STS_OKAY    = 2'd0;
  localparam ctrl_status_t CTRL_STS_CMDERR  = 2'd1;
  localparam ctrl_status_t CTRL_STS_TSERR   = 2'd2;
  localparam ctrl_status_t CTRL_STS_WARNING = 2'd3;

  // ------------------------------------------------------------------------
  // clock enable block register map
  // ------------------------------------------------------------------------
  localparam ctrl_addr_t CLK_EN_CONTROL      = 20'h0;
  localparam int         CLK_EN              = 0;
  // only the enable bit reads back
  localparam ctrl_data_t CLK_EN_CONTROL_MASK = 32'h0000_0001;
  localparam int         CLK_EN_REGMAP_SIZE  = 4;

  // ------------------------------------------------------------------------
  // info block register map
  // ------------------------------------------------------------------------
  localparam ctrl_addr_t INFO_ID          = 20'h0;
  localparam ctrl_addr_t INFO_SCRATCH     = 20'h4;
  localparam ctrl_addr_t INFO_NUM_CLKS    = 20'h8;
  localparam int         INFO_REGMAP_SIZE = 16;

  // identification word of this subsystem
  localparam ctrl_data_t CLK_CTRL_ID = 32'hc10c_e0a1;

endpackage

`default_nettype wire

/* src/ctrlport_req_stage.sv */
// ctrlport request broadcast stage
`timescale 1ns/1ps
`default_nettype none

module ctrlport_req_stage (
  input  logic                     ctrlport_clk,
  input  logic                     ctrlport_rst,
  // request from the bus master
  input  logic                     req_wr,
  input  logic                     req_rd,
  input  clk_ctrl_pkg::ctrl_addr_t req_addr,
  input  clk_ctrl_pkg::ctrl_data_t req_data,
  // registered request to every register block
  output logic                     b_req_wr,
  output logic                     b_req_rd,
  output clk_ctrl_pkg::ctrl_addr_t b_req_addr,
  output clk_ctrl_pkg::ctrl_data_t b_req_data,
  // response owed, goes to the combiner
  output logic                     req_issued
);

  // ------------------------------------------------------------------------
  // strobes
  // ------------------------------------------------------------------------
  always_ff @(posedge ctrlport_clk) begin
    if (ctrlport_rst) begin
      b_req_wr   <= 1'b0;
      b_req_rd   <= 1'b0;
      req_issued <= 1'b0;
    end else begin
      b_req_wr   <= req_wr;
      // write wins over a read in the same cycle
      b_req_rd   <= req_rd & ~req_wr;
      // one response owed per strobe cycle
      req_issued <= req_wr | req_rd;
    end
  end

  // ------------------------------------------------------------------------
  // address and data
  // ------------------------------------------------------------------------
  // only looked at while a strobe is set
  always_ff @(posedge ctrlport_clk) begin
    b_req_addr <= req_addr;
    b_req_data <= req_data;
  end

endmodule

`default_nettype wire

/* src/clk_gate.sv */
// glitch-free clock gate
`timescale 1ns/1ps
`default_nettype none

module clk_gate (
  // free-running source clock
  input  logic clk_in,
  // enable, ctrlport_clk domain
  input  logic en,
  // gated copy of clk_in
  output logic clk_out
);

  logic en_meta;
  logic en_sync;
  logic en_latch;

  // ------------------------------------------------------------------------
  // enable synchronizer
  // ------------------------------------------------------------------------
  // two flops into clk_in, no reset
  // en is a quasi-static register bit
  always_ff @(posedge clk_in) begin
    en_meta <= en;
    en_sync <= en_meta;
  end

  // ------------------------------------------------------------------------
  // gate
  // ------------------------------------------------------------------------
  // latch open only while clk_in is low
  // so the enable never changes during a high phase
  always_latch begin
    if (!clk_in) begin
      en_latch <= en_sync;
    end
  end

  // output starts and stops on a low phase, full pulses only
  assign clk_out = clk_in & en_latch;

endmodule

`default_nettype wire

/* src/clock_en_control.sv */
// clock enable control register block
`timescale 1ns/1ps
`default_nettype none

module clock_en_control #(
  parameter clk_ctrl_pkg::ctrl_addr_t BASE_ADDRESS = '0,
  parameter int                       REGMAP_SIZE  = 4
) (
  input  logic                       ctrlport_clk,
  input  logic                       ctrlport_rst,
  // broadcast request
  input  logic                       b_req_wr,
  input  logic                       b_req_rd,
  input  clk_ctrl_pkg::ctrl_addr_t   b_req_addr,
  input  clk_ctrl_pkg::ctrl_data_t   b_req_data,
  // block response
  output logic                       blk_resp_ack,
  output clk_ctrl_pkg::ctrl_status_t blk_resp_status,
  output clk_ctrl_pkg::ctrl_data_t   blk_resp_data,
  // free-running source and gated output
  input  logic                       clk_in,
  output logic                       clk_out
);

  import clk_ctrl_pkg::*;

  // enable register, full word kept, only masked bits read back
  ctrl_data_t   clk_ctrl_reg;

  ctrl_addr_t   offset;
  logic         in_range;
  logic         hit;
  logic         reg_wr;
  ctrl_status_t status_nxt;
  ctrl_data_t   data_nxt;

  // ------------------------------------------------------------------------
  // address decode
  // ------------------------------------------------------------------------
  assign offset   = b_req_addr - BASE_ADDRESS;
  // lower bound check guards against offset wrap below the base
  assign in_range = (b_req_addr >= BASE_ADDRESS) &&
                    (offset < ctrl_addr_t'(REGMAP_SIZE));

  always_comb begin
    hit        = 1'b0;
    reg_wr     = 1'b0;
    status_nxt = CTRL_STS_OKAY;
    data_nxt   = '0;
    // out of window: stay silent, another block or the combiner answers
    if ((b_req_wr || b_req_rd) && in_range) begin
      hit = 1'b1;
      case (offset)
        CLK_EN_CONTROL: begin
          if (b_req_wr) begin
            reg_wr = 1'b1;
          end else begin
            data_nxt = clk_ctrl_reg & CLK_EN_CONTROL_MASK;
          end
        end
        // undefined offset inside the window
        default: begin
          status_nxt = CTRL_STS_CMDERR;
        end
      endcase
    end
  end

  // ------------------------------------------------------------------------
  // register and response
  // ------------------------------------------------------------------------
  always_ff @(posedge ctrlport_clk) begin
    if (ctrlport_rst) begin
      blk_resp_ack <= 1'b0;
      clk_ctrl_reg <= '0;
    end else begin
      blk_resp_ack <= hit;
      if (reg_wr) begin
        clk_ctrl_reg <= b_req_data;
      end
    end
  end

  // response payload, qualified by blk_resp_ack
  always_ff @(posedge ctrlport_clk) begin
    blk_resp_status <= status_nxt;
    blk_resp_data   <= data_nxt;
  end

  // ------------------------------------------------------------------------
  // clock gate
  // ------------------------------------------------------------------------
  clk_gate i_clk_gate (
    .clk_in  (clk_in),
    .en      (clk_ctrl_reg[CLK_EN]),
    .clk_out (clk_out)
  );

endmodule

`default_nettype wire

/* src/clk_ctrl_info.sv */
// clock control info register block
`timescale 1ns/1ps
`default_nettype none

module clk_ctrl_info #(
  parameter clk_ctrl_pkg::ctrl_addr_t BASE_ADDRESS = '0,
  parameter int                       NUM_CLK_OUTS = 2
) (
  input  logic                       ctrlport_clk,
  input  logic                       ctrlport_rst,
  // broadcast request
  input  logic                       b_req_wr,
  input  logic                       b_req_rd,
  input  clk_ctrl_pkg::ctrl_addr_t   b_req_addr,
  input  clk_ctrl_pkg::ctrl_data_t   b_req_data,
  // block response
  output logic                       blk_resp_ack,
  output clk_ctrl_pkg::ctrl_status_t blk_resp_status,
  output clk_ctrl_pkg::ctrl_data_t   blk_resp_data
);

  import clk_ctrl_pkg::*;

  ctrl_data_t   scratch_reg;

  ctrl_addr_t   offset;
  logic         in_range;
  logic         hit;
  logic         scratch_wr;
  ctrl_status_t status_nxt;
  ctrl_data_t   data_nxt;

  // ------------------------------------------------------------------------
  // address decode
  // ------------------------------------------------------------------------
  assign offset   = b_req_addr - BASE_ADDRESS;
  assign in_range = (b_req_addr >= BASE_ADDRESS) &&
                    (offset < ctrl_addr_t'(INFO_REGMAP_SIZE));

  always_comb begin
    hit        = 1'b0;
    scratch_wr = 1'b0;
    status_nxt = CTRL_STS_OKAY;
    data_nxt   = '0;
    if ((b_req_wr || b_req_rd) && in_range) begin
      hit = 1'b1;
      case (offset)
        // read only
        INFO_ID: begin
          if (b_req_wr) begin
            status_nxt = CTRL_STS_CMDERR;
          end else begin
            data_nxt = CLK_CTRL_ID;
          end
        end
        INFO_SCRATCH: begin
          if (b_req_wr) begin
            scratch_wr = 1'b1;
          end else begin
            data_nxt = scratch_reg;
          end
        end
        // read only, number of gated outputs
        INFO_NUM_CLKS: begin
          if (b_req_wr) begin
            status_nxt = CTRL_STS_CMDERR;
          end else begin
            data_nxt = ctrl_data_t'(NUM_CLK_OUTS);
          end
        end
        default: begin
          status_nxt = CTRL_STS_CMDERR;
        end
      endcase
    end
  end

  // ------------------------------------------------------------------------
  // scratch and response
  // ------------------------------------------------------------------------
  always_ff @(posedge ctrlport_clk) begin
    if (ctrlport_rst) begin
      blk_resp_ack <= 1'b0;
      scratch_reg  <= '0;
    end else begin
      blk_resp_ack <= hit;
      if (scratch_wr) begin
        scratch_reg <= b_req_data;
      end
    end
  end

  always_ff @(posedge ctrlport_clk) begin
    blk_resp_status <= status_nxt;
    blk_resp_data   <= data_nxt;
  end

endmodule

`default_nettype wire

/* src/ctrlport_resp_combiner.sv */
// ctrlport response combiner
`timescale 1ns/1ps
`default_nettype none

module ctrlport_resp_combiner #(
  parameter int NUM_RESP = 3
) (
  input  logic                                          ctrlport_clk,
  input  logic                                          ctrlport_rst,
  // request went out, block responses due one cycle later
  input  logic                                          req_issued,
  // concatenated block responses
  input  logic [NUM_RESP-1:0]                           all_ack,
  input  logic [NUM_RESP*clk_ctrl_pkg::CTRL_STS_W-1:0]  all_status,
  input  logic [NUM_RESP*clk_ctrl_pkg::CTRL_DATA_W-1:0] all_data,
  // merged response
  output logic                                          resp_ack,
  output clk_ctrl_pkg::ctrl_status_t                    resp_status,
  output clk_ctrl_pkg::ctrl_data_t                      resp_data
);

  import clk_ctrl_pkg::*;

  // high in the cycle the block responses are due
  logic         owed;
  logic         any_ack;
  ctrl_status_t merged_status;
  ctrl_data_t   merged_data;

  // ------------------------------------------------------------------------
  // merge
  // ------------------------------------------------------------------------
  // windows do not overlap, at most one ack per cycle
  always_comb begin
    any_ack       = |all_ack;
    merged_status = CTRL_STS_OKAY;
    merged_data   = '0;
    for (int i = 0; i < NUM_RESP; i++) begin
      if (all_ack[i]) begin
        merged_status |= all_status[i*CTRL_STS_W +: CTRL_STS_W];
        merged_data   |= all_data[i*CTRL_DATA_W +: CTRL_DATA_W];
      end
    end
  end

  // ------------------------------------------------------------------------
  // registered response
  // ------------------------------------------------------------------------
  always_ff @(posedge ctrlport_clk) begin
    if (ctrlport_rst) begin
      owed     <= 1'b0;
      resp_ack <= 1'b0;
    end else begin
      owed     <= req_issued;
      // every owed cycle acks, claimed or not
      resp_ack <= owed;
    end
  end

  always_ff @(posedge ctrlport_clk) begin
    if (owed && any_ack) begin
      resp_status <= merged_status;
      resp_data   <= merged_data;
    end else if (owed) begin
      // nobody claimed the address
      resp_status <= CTRL_STS_CMDERR;
      resp_data   <= '0;
    end else begin
      // stray acks outside an owed cycle are dropped
      resp_status <= CTRL_STS_OKAY;
      resp_data   <= '0;
    end
  end

endmodule

`default_nettype wire

/* src/clk_ctrl_top.sv */
// clock enable control subsystem
`timescale 1ns/1ps
`default_nettype none

module clk_ctrl_top #(
  parameter int                       NUM_CLK_OUTS = 2,
  parameter clk_ctrl_pkg::ctrl_addr_t INFO_BASE    = 20'h000,
  parameter clk_ctrl_pkg::ctrl_addr_t CLK_BASE     = 20'h100,
  parameter clk_ctrl_pkg::ctrl_addr_t CLK_STRIDE   = 20'h010
) (
  input  logic                       ctrlport_clk,
  input  logic                       ctrlport_rst,
  // ctrlport request
  input  logic                       req_wr,
  input  logic                       req_rd,
  input  clk_ctrl_pkg::ctrl_addr_t   req_addr,
  input  clk_ctrl_pkg::ctrl_data_t   req_data,
  // ctrlport response
  output logic                       resp_ack,
  output clk_ctrl_pkg::ctrl_status_t resp_status,
  output clk_ctrl_pkg::ctrl_data_t   resp_data,
  // clocks
  input  logic                       clk_in,
  output logic [NUM_CLK_OUTS-1:0]    clk_out
);

  import clk_ctrl_pkg::*;

  // slot 0 is the info block, slots 1.. are the clock blocks
  localparam int NUM_RESP = NUM_CLK_OUTS + 1;

  logic       b_req_wr;
  logic       b_req_rd;
  ctrl_addr_t b_req_addr;
  ctrl_data_t b_req_data;
  logic       req_issued;

  logic [NUM_RESP-1:0]             all_ack;
  logic [NUM_RESP*CTRL_STS_W-1:0]  all_status;
  logic [NUM_RESP*CTRL_DATA_W-1:0] all_data;

  // ------------------------------------------------------------------------
  // request side
  // ------------------------------------------------------------------------
  ctrlport_req_stage i_req_stage (
    .ctrlport_clk (ctrlport_clk),
    .ctrlport_rst (ctrlport_rst),
    .req_wr       (req_wr),
    .req_rd       (req_rd),
    .req_addr     (req_addr),
    .req_data     (req_data),
    .b_req_wr     (b_req_wr),
    .b_req_rd     (b_req_rd),
    .b_req_addr   (b_req_addr),
    .b_req_data   (b_req_data),
    .req_issued   (req_issued)
  );

  // ------------------------------------------------------------------------
  // register blocks
  // ------------------------------------------------------------------------
  clk_ctrl_info #(
    .BASE_ADDRESS (INFO_BASE),
    .NUM_CLK_OUTS (NUM_CLK_OUTS)
  ) i_info (
    .ctrlport_clk    (ctrlport_clk),
    .ctrlport_rst    (ctrlport_rst),
    .b_req_wr        (b_req_wr),
    .b_req_rd        (b_req_rd),
    .b_req_addr      (b_req_addr),
    .b_req_data      (b_req_data),
    .blk_resp_ack    (all_ack[0]),
    .blk_resp_status (all_status[0 +: CTRL_STS_W]),
    .blk_resp_data   (all_data[0 +: CTRL_DATA_W])
  );

  // one window per gated clock, CLK_STRIDE apart
  for (genvar k = 0; k < NUM_CLK_OUTS; k++) begin : g_clk
    clock_en_control #(
      .BASE_ADDRESS (CLK_BASE + ctrl_addr_t'(k) * CLK_STRIDE),
      .REGMAP_SIZE  (CLK_EN_REGMAP_SIZE)
    ) i_clock_en_control (
      .ctrlport_clk    (ctrlport_clk),
      .ctrlport_rst    (ctrlport_rst),
      .b_req_wr        (b_req_wr),
      .b_req_rd        (b_req_rd),
      .b_req_addr      (b_req_addr),
      .b_req_data      (b_req_data),
      .blk_resp_ack    (all_ack[k+1]),
      .blk_resp_status (all_status[(k+1)*CTRL_STS_W +: CTRL_STS_W]),
      .blk_resp_data   (all_data[(k+1)*CTRL_DATA_W +: CTRL_DATA_W]),
      .clk_in          (clk_in),
      .clk_out         (clk_out[k])
    );
  end

  // ------------------------------------------------------------------------
  // response side
  // ------------------------------------------------------------------------
  ctrlport_resp_combiner #(
    .NUM_RESP (NUM_RESP)
  ) i_resp_combiner (
    .ctrlport_clk (ctrlport_clk),
    .ctrlport_rst (ctrlport_rst),
    .req_issued   (req_issued),
    .all_ack      (all_ack),
    .all_status   (all_status),
    .all_data     (all_data),
    .resp_ack     (resp_ack),
    .resp_status  (resp_status),
    .resp_data    (resp_data)
  );

endmodule

`default_nettype wire

/* bench/tb_clock_gen.sv */
// testbench clock and reset source
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
  parameter real PERIOD_NS    = 8.0,
  parameter int  RESET_CYCLES = 16
) (
  output logic clk,
  output logic rst
);

  // free-running clock, starts low
  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2.0) clk = ~clk;
  end

  // reset held for RESET_CYCLES rising edges, released on a falling edge
  initial begin
    rst = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
  end

endmodule

`default_nettype wire

/* bench/clk_ctrl_tb.sv */
// clock control subsystem testbench
`timescale 1ns/1ps
`default_nettype none

module clk_ctrl_tb;

  import clk_ctrl_pkg::*;

  // default map of the DUT
  localparam ctrl_addr_t INFO_BASE  = 20'h000;
  localparam ctrl_addr_t CLK_BASE   = 20'h100;
  localparam ctrl_addr_t CLK_STRIDE = 20'h010;
  localparam int         NUM_CLKS   = 2;
  localparam int         PIPE_LEN   = 12;
  localparam logic [31:0] LFSR_SEED = 32'hdce2e0ba;

  // ------------------------------------------------------------------------
  // watchdog budget
  // ------------------------------------------------------------------------
  // one transaction is about five ctrlport cycles
  localparam int TXN_NS      = 5 * 8;
  localparam int NUM_TXN     = 29;
  // three gating phases, settle plus count window in clk_in periods
  localparam int GATE_NS     = 3 * (52 * 6);
  localparam int PIPE_NS     = (PIPE_LEN + 5) * 8;
  localparam int RESET_NS    = 18 * 8;
  localparam int WATCHDOG_NS = 2 * (RESET_NS + NUM_TXN * TXN_NS + GATE_NS + PIPE_NS) + 1000;

  logic                ctrlport_clk;
  logic                ctrlport_rst;
  logic                clk_in;
  logic                req_wr;
  logic                req_rd;
  ctrl_addr_t          req_addr;
  ctrl_data_t          req_data;
  logic                resp_ack;
  ctrl_status_t        resp_status;
  ctrl_data_t          resp_data;
  logic [NUM_CLKS-1:0] clk_out;

  int          error_count;
  int          tests_run;
  int          tests_failed;
  logic [31:0] lfsr_state;
  // edge counting window for the gating test
  logic        counting;
  int          edge_count0;
  int          edge_count1;

  // ------------------------------------------------------------------------
  // clocks and DUT
  // ------------------------------------------------------------------------
  tb_clock_gen #(.PERIOD_NS(8.0), .RESET_CYCLES(16)) i_ctrl_clk_gen (
    .clk (ctrlport_clk),
    .rst (ctrlport_rst)
  );

  // source clock, its reset output unused
  tb_clock_gen #(.PERIOD_NS(6.0), .RESET_CYCLES(0)) i_src_clk_gen (
    .clk (clk_in),
    .rst ()
  );

  clk_ctrl_top i_dut (
    .ctrlport_clk (ctrlport_clk),
    .ctrlport_rst (ctrlport_rst),
    .req_wr       (req_wr),
    .req_rd       (req_rd),
    .req_addr     (req_addr),
    .req_data     (req_data),
    .resp_ack     (resp_ack),
    .resp_status  (resp_status),
    .resp_data    (resp_data),
    .clk_in       (clk_in),
    .clk_out      (clk_out)
  );

  always @(posedge clk_out[0]) begin
    if (counting) begin
      edge_count0++;
    end
  end

  always @(posedge clk_out[1]) begin
    if (counting) begin
      edge_count1++;
    end
  end

  // ------------------------------------------------------------------------
  // helpers
  // ------------------------------------------------------------------------
  // fibonacci lfsr, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic rand_bit(output logic b);
    lfsr_state = lfsr_next(lfsr_state);
    b = lfsr_state[0];
  endtask

  // one step per bit taken
  task automatic rand_word(output logic [31:0] w);
    logic b;
    w = '0;
    for (int i = 0; i < 32; i++) begin
      rand_bit(b);
      w = {w[30:0], b};
    end
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] expected);
    if (got !== expected) begin
      $display("FAIL %s: got 0x%08h, expected 0x%08h", name, got, expected);
      error_count++;
    end
  endtask

  // a count one edge either side of the window is accepted
  function automatic int tolerate_one(input int count, input int expected);
    if (count >= expected - 1 && count <= expected + 1) begin
      return expected;
    end
    return count;
  endfunction

  // single request, response three rising edges later
  task automatic transact(input logic wr, input ctrl_addr_t addr, input ctrl_data_t wdata,
                          input ctrl_status_t exp_status, input ctrl_data_t exp_data);
    @(negedge ctrlport_clk);
    req_wr   = wr;
    req_rd   = ~wr;
    req_addr = addr;
    req_data = wr ? wdata : '0;
    @(posedge ctrlport_clk);
    @(negedge ctrlport_clk);
    req_wr = 1'b0;
    req_rd = 1'b0;
    repeat (2) @(posedge ctrlport_clk);
    @(negedge ctrlport_clk);
    if (resp_ack !== 1'b1) begin
      $display("no response ack for %s at address 0x%05h", wr ? "write" : "read", addr);
      error_count++;
    end
    check_value("resp_status", resp_status, exp_status);
    check_value("resp_data", resp_data, exp_data);
  endtask

  task automatic report_test(input string name, input int errors_at_start);
    tests_run++;
    if (error_count == errors_at_start) begin
      $display("%-14s ok", name);
    end else begin
      tests_failed++;
      $display("%-14s %0d errors", name, error_count - errors_at_start);
    end
  endtask

  // ------------------------------------------------------------------------
  // tests
  // ------------------------------------------------------------------------
  task automatic test_info_reads();
    int errs;
    errs = error_count;
    transact(1'b0, INFO_BASE + INFO_ID, '0, CTRL_STS_OKAY, CLK_CTRL_ID);
    transact(1'b0, INFO_BASE + INFO_NUM_CLKS, '0, CTRL_STS_OKAY, 32'd2);
    report_test("info_reads", errs);
  endtask

  task automatic test_scratch();
    int         errs;
    ctrl_data_t w;
    errs = error_count;
    // still at reset value
    transact(1'b0, INFO_BASE + INFO_SCRATCH, '0, CTRL_STS_OKAY, '0);
    for (int i = 0; i < 4; i++) begin
      rand_word(w);
      transact(1'b1, INFO_BASE + INFO_SCRATCH, w, CTRL_STS_OKAY, '0);
      transact(1'b0, INFO_BASE + INFO_SCRATCH, '0, CTRL_STS_OKAY, w);
    end
    report_test("scratch", errs);
  endtask

  task automatic test_enable_regs();
    int         errs;
    ctrl_addr_t a;
    errs = error_count;
    for (int k = 0; k < NUM_CLKS; k++) begin
      a = CLK_BASE + ctrl_addr_t'(k) * CLK_STRIDE + CLK_EN_CONTROL;
      transact(1'b1, a, 32'hffff_ffff, CTRL_STS_OKAY, '0);
      transact(1'b0, a, '0, CTRL_STS_OKAY, CLK_EN_CONTROL_MASK);
      transact(1'b1, a, '0, CTRL_STS_OKAY, '0);
      transact(1'b0, a, '0, CTRL_STS_OKAY, '0);
    end
    report_test("enable_regs", errs);
  endtask

  task automatic test_errors();
    int errs;
    errs = error_count;
    // undefined offset in the info window
    transact(1'b0, INFO_BASE + 20'hc, '0, CTRL_STS_CMDERR, '0);
    transact(1'b1, INFO_BASE + INFO_ID, 32'h1234_5678, CTRL_STS_CMDERR, '0);
    // inside the stride, past the 4 byte window
    transact(1'b0, CLK_BASE + 20'h8, '0, CTRL_STS_CMDERR, '0);
    transact(1'b0, 20'h8_0000, '0, CTRL_STS_CMDERR, '0);
    report_test("errors", errs);
  endtask

  task automatic gate_phase(input logic en0, input logic en1);
    int high_seen;
    high_seen = 0;
    transact(1'b1, CLK_BASE + CLK_EN_CONTROL, {31'b0, en0}, CTRL_STS_OKAY, '0);
    transact(1'b1, CLK_BASE + CLK_STRIDE + CLK_EN_CONTROL, {31'b0, en1}, CTRL_STS_OKAY, '0);
    // synchronizer and latch settle well inside this
    repeat (10) @(posedge clk_in);
    // window edges on falling clk_in, away from output rising edges
    @(negedge clk_in);
    edge_count0 = 0;
    edge_count1 = 0;
    counting    = 1'b1;
    for (int i = 0; i < 40; i++) begin
      @(posedge clk_in);
      // sample inside the high phase of clk_in
      #1;
      if ((!en0 && clk_out[0] !== 1'b0) || (!en1 && clk_out[1] !== 1'b0)) begin
        high_seen++;
      end
      @(negedge clk_in);
    end
    counting = 1'b0;
    if (en0) begin
      check_value("clk_out[0] edges", tolerate_one(edge_count0, 40), 40);
    end else begin
      check_value("clk_out[0] edges", edge_count0, 0);
    end
    if (en1) begin
      check_value("clk_out[1] edges", tolerate_one(edge_count1, 40), 40);
    end else begin
      check_value("clk_out[1] edges", edge_count1, 0);
    end
    // disabled outputs must stay low, not only lack rising edges
    check_value("disabled clk_out high samples", high_seen, 0);
  endtask

  task automatic test_gating();
    int errs;
    errs = error_count;
    gate_phase(1'b1, 1'b0);
    gate_phase(1'b0, 1'b1);
    gate_phase(1'b0, 1'b0);
    report_test("gating", errs);
  endtask

  // back-to-back scratch traffic, one request per cycle
  task automatic test_pipelining();
    logic       p_wr   [PIPE_LEN];
    ctrl_data_t p_data [PIPE_LEN];
    ctrl_data_t p_exp  [PIPE_LEN];
    ctrl_data_t model;
    logic       b;
    int         errs;
    errs  = error_count;
    model = '0;
    // expected responses from the scratch model, first request a write
    for (int i = 0; i < PIPE_LEN; i++) begin
      rand_bit(b);
      p_wr[i] = (i == 0) || b;
      if (p_wr[i]) begin
        rand_word(p_data[i]);
        model    = p_data[i];
        p_exp[i] = '0;
      end else begin
        p_data[i] = '0;
        p_exp[i]  = model;
      end
    end
    // request j goes out at falling edge j, its response shows at j+3
    for (int j = 0; j < PIPE_LEN + 4; j++) begin
      @(negedge ctrlport_clk);
      if (j >= 3 && j - 3 < PIPE_LEN) begin
        if (resp_ack !== 1'b1) begin
          $display("no response ack for pipelined request %0d", j - 3);
          error_count++;
        end
        check_value("resp_status", resp_status, CTRL_STS_OKAY);
        check_value("resp_data", resp_data, p_exp[j-3]);
      end else if (resp_ack !== 1'b0) begin
        $display("unexpected response ack in pipeline cycle %0d", j);
        error_count++;
      end
      if (j < PIPE_LEN) begin
        req_wr   = p_wr[j];
        req_rd   = ~p_wr[j];
        req_addr = INFO_BASE + INFO_SCRATCH;
        req_data = p_data[j];
      end else begin
        req_wr = 1'b0;
        req_rd = 1'b0;
      end
    end
    report_test("pipelining", errs);
  endtask

  // ------------------------------------------------------------------------
  // main sequence and watchdog
  // ------------------------------------------------------------------------
  initial begin
    req_wr       = 1'b0;
    req_rd       = 1'b0;
    req_addr     = '0;
    req_data     = '0;
    counting     = 1'b0;
    edge_count0  = 0;
    edge_count1  = 0;
    error_count  = 0;
    tests_run    = 0;
    tests_failed = 0;
    lfsr_state   = LFSR_SEED;
    @(negedge ctrlport_rst);
    repeat (2) @(posedge ctrlport_clk);
    test_info_reads();
    test_scratch();
    test_enable_regs();
    test_errors();
    test_gating();
    test_pipelining();
    $display("%0d run, %0d failed, %0d check errors", tests_run, tests_failed, error_count);
    if (error_count == 0 && tests_failed == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS * 1ns);
    $display("watchdog expired before the tests completed");
    $display("tests failed");
    $finish;
  end

endmodule

`default_nettype wire

/* verilog.f */
src/clk_ctrl_pkg.sv
src/ctrlport_req_stage.sv
src/clk_gate.sv
src/clock_en_control.sv
src/clk_ctrl_info.sv
src/ctrlport_resp_combiner.sv
src/clk_ctrl_top.sv
bench/tb_clock_gen.sv
bench/clk_ctrl_tb.sv
